// ==== logic/ntm_trainer_cfg.svh ====
// NTM trainer dimensions
`ifndef NTM_TRAINER_CFG_SVH
`define NTM_TRAINER_CFG_SVH

//////////////////////////////////////////////////
// Matrix shape
//////////////////////////////////////////////////

// Rows of dW and entries of db
`define NTM_L 4
// Input columns of dW
`define NTM_X 4

//////////////////////////////////////////////////
// Word widths
//////////////////////////////////////////////////

// Signed input sample
`define NTM_DATA_W 16
// Signed sum, wraps at this width
`define NTM_ACC_W 32

`endif

// ==== logic/ntm_trainer_pkg.sv ====
// NTM trainer shared types
`include "ntm_trainer_cfg.svh"

package ntm_trainer_pkg;

  //////////////////////////////////////////////////
  // Index and data words
  //////////////////////////////////////////////////

  // Row index, l in 0 to L-1
  typedef logic [$clog2(`NTM_L)-1:0] row_t;

  // Column index, x in 0 to X-1
  typedef logic [$clog2(`NTM_X)-1:0] col_t;

  // Wrapping accumulator word
  typedef logic signed [`NTM_ACC_W-1:0] acc_t;

  //////////////////////////////////////////////////
  // Streams
  //////////////////////////////////////////////////

  // One input element from the host
  typedef struct packed {
    logic                          x_valid;
    logic                          d_valid;
    logic signed [`NTM_DATA_W-1:0] data;
  } ntm_sample_t;

  // One result on the output stream
  typedef struct packed {
    logic w_valid;
    logic b_valid;
    row_t row;
    col_t col;
    acc_t value;
  } ntm_grad_t;

endpackage

// ==== logic/ntm_weight_gradient.sv ====
// Weight gradient accumulator
`timescale 1ns/10ps
`include "ntm_trainer_cfg.svh"

module ntm_weight_gradient (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         clear,
  input  logic                         accumulate_en,
  input  ntm_trainer_pkg::ntm_sample_t sample,
  input  ntm_trainer_pkg::row_t        rd_row,
  input  ntm_trainer_pkg::col_t        rd_col,
  output ntm_trainer_pkg::acc_t        rd_value
);

  import ntm_trainer_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // x(t;x) of the current time step
  logic signed [`NTM_DATA_W-1:0] x_mem [`NTM_X];

  // Next x slot and next d row
  col_t x_ptr;
  row_t d_row;

  // dW(l;x) sums
  acc_t acc [`NTM_L][`NTM_X];

  // d(t;l)·x(t;c) for every column
  acc_t prod [`NTM_X];

  // Accepted strobes
  logic x_wr;
  logic d_wr;

  // Strobes only count inside a pass, clear wins
  assign x_wr = accumulate_en & sample.x_valid & ~clear;
  assign d_wr = accumulate_en & sample.d_valid & ~clear;

  //////////////////////////////////////////////////
  // x register file
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (x_wr) begin
      x_mem[x_ptr] <= sample.data;
    end
  end

  // Position counters, both wrap at the end of the vector
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      x_ptr <= '0;
      d_row <= '0;
    end else if (clear) begin
      x_ptr <= '0;
      d_row <= '0;
    end else begin
      if (x_wr) begin
        x_ptr <= (x_ptr == col_t'(`NTM_X - 1)) ? '0 : x_ptr + 1'b1;
      end
      if (d_wr) begin
        d_row <= (d_row == row_t'(`NTM_L - 1)) ? '0 : d_row + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Outer product row
  //////////////////////////////////////////////////

  // Both operands sign-extended first, product wraps at ACC_W
  always_comb begin
    for (int c = 0; c < `NTM_X; c++) begin
      prod[c] = acc_t'(sample.data) * acc_t'(x_mem[c]);
    end
  end

  // One whole row of dW per d strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < `NTM_L; l++) begin
        for (int c = 0; c < `NTM_X; c++) begin
          acc[l][c] <= '0;
        end
      end
    end else if (clear) begin
      for (int l = 0; l < `NTM_L; l++) begin
        for (int c = 0; c < `NTM_X; c++) begin
          acc[l][c] <= '0;
        end
      end
    end else if (d_wr) begin
      for (int c = 0; c < `NTM_X; c++) begin
        acc[d_row][c] <= acc[d_row][c] + prod[c];
      end
    end
  end

  // Combinational read port for the readout unit
  assign rd_value = acc[rd_row][rd_col];

endmodule

// ==== logic/ntm_bias_gradient.sv ====
// Bias gradient accumulator
`timescale 1ns/10ps
`include "ntm_trainer_cfg.svh"

module ntm_bias_gradient (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         clear,
  input  logic                         accumulate_en,
  input  ntm_trainer_pkg::ntm_sample_t sample,
  input  ntm_trainer_pkg::row_t        rd_row,
  output ntm_trainer_pkg::acc_t        rd_value
);

  import ntm_trainer_pkg::*;

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  // Row that the next d strobe belongs to
  row_t d_row;

  // db(l) sums
  acc_t acc [`NTM_L];

  // Accepted d strobe, x strobes pass by
  logic d_wr;

  assign d_wr = accumulate_en & sample.d_valid & ~clear;

  // Row counter tracks the weight unit's own counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      d_row <= '0;
    end else if (clear) begin
      d_row <= '0;
    end else if (d_wr) begin
      d_row <= (d_row == row_t'(`NTM_L - 1)) ? '0 : d_row + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Sums
  //////////////////////////////////////////////////

  // Sample sign-extended, then a wrapping add
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int l = 0; l < `NTM_L; l++) begin
        acc[l] <= '0;
      end
    end else if (clear) begin
      for (int l = 0; l < `NTM_L; l++) begin
        acc[l] <= '0;
      end
    end else if (d_wr) begin
      acc[d_row] <= acc[d_row] + acc_t'(sample.data);
    end
  end

  // Combinational read port
  assign rd_value = acc[rd_row];

endmodule

// ==== logic/ntm_gradient_readout.sv ====
// Gradient pass controller and readout
`timescale 1ns/10ps
`include "ntm_trainer_cfg.svh"

module ntm_gradient_readout (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  input  logic                       finish,
  output logic                       clear,
  output logic                       accumulate_en,
  output ntm_trainer_pkg::row_t      rd_row,
  output ntm_trainer_pkg::col_t      rd_col,
  input  ntm_trainer_pkg::acc_t      w_value,
  input  ntm_trainer_pkg::acc_t      b_value,
  output ntm_trainer_pkg::ntm_grad_t grad,
  output logic                       ready
);

  import ntm_trainer_pkg::*;

  //////////////////////////////////////////////////
  // Pass FSM
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    idle,
    accumulate,
    read_w,
    read_b,
    done
  } state_t;

  state_t state;

  // Last read address of each sweep
  logic last_col;
  logic last_row;

  // Registered output fields
  logic w_valid_q;
  logic b_valid_q;
  row_t row_q;
  col_t col_q;
  acc_t value_q;

  assign last_col = (rd_col == col_t'(`NTM_X - 1));
  assign last_row = (rd_row == row_t'(`NTM_L - 1));

  // Start is honoured outside readout only
  assign clear = start & ((state == idle) | (state == accumulate));

  // Strobes open the cycle after start
  assign accumulate_en = (state == accumulate);

  // State and read addresses
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= idle;
      rd_row <= '0;
      rd_col <= '0;
    end else begin
      case (state)
        idle: begin
          // A lone finish does nothing here
          if (start) begin
            state <= accumulate;
          end
        end
        accumulate: begin
          if (finish) begin
            // Address (0;0) is presented during the first read cycle
            state  <= read_w;
            rd_row <= '0;
            rd_col <= '0;
          end
        end
        read_w: begin
          // Row-major sweep of dW
          if (last_col) begin
            rd_col <= '0;
            if (last_row) begin
              rd_row <= '0;
              state  <= read_b;
            end else begin
              rd_row <= rd_row + 1'b1;
            end
          end else begin
            rd_col <= rd_col + 1'b1;
          end
        end
        read_b: begin
          if (last_row) begin
            rd_row <= '0;
            state  <= done;
          end else begin
            rd_row <= rd_row + 1'b1;
          end
        end
        done: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  // Valid flags and ready, one cycle behind the read address
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      w_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
      ready     <= 1'b0;
    end else begin
      w_valid_q <= (state == read_w);
      b_valid_q <= (state == read_b);
      // Pulse on the way out of done
      ready     <= (state == done);
    end
  end

  // Result word with its indices
  always_ff @(posedge CLK) begin
    row_q <= rd_row;
    // db entries carry column zero
    col_q   <= (state == read_w) ? rd_col : '0;
    value_q <= (state == read_w) ? w_value : b_value;
  end

  assign grad = '{
    w_valid: w_valid_q,
    b_valid: b_valid_q,
    row:     row_q,
    col:     col_q,
    value:   value_q
  };

endmodule

// ==== logic/ntm_trainer.sv ====
// NTM trainer gradient core
`timescale 1ns/10ps

module ntm_trainer (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         start,
  input  logic                         finish,
  input  ntm_trainer_pkg::ntm_sample_t sample,
  output ntm_trainer_pkg::ntm_grad_t   grad,
  output logic                         ready
);

  import ntm_trainer_pkg::*;

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  // Pass control from the readout unit
  logic clear;
  logic accumulate_en;

  // Shared read address
  row_t rd_row;
  col_t rd_col;

  // Read data from both gradient units
  acc_t w_value;
  acc_t b_value;

  //////////////////////////////////////////////////
  // Gradient units
  //////////////////////////////////////////////////

  // dW(l;x), both units see the same strobes
  ntm_weight_gradient u_weight (
    .CLK           (CLK),
    .RST           (RST),
    .clear         (clear),
    .accumulate_en (accumulate_en),
    .sample        (sample),
    .rd_row        (rd_row),
    .rd_col        (rd_col),
    .rd_value      (w_value)
  );

  // db(l)
  ntm_bias_gradient u_bias (
    .CLK           (CLK),
    .RST           (RST),
    .clear         (clear),
    .accumulate_en (accumulate_en),
    .sample        (sample),
    .rd_row        (rd_row),
    .rd_value      (b_value)
  );

  //////////////////////////////////////////////////
  // Readout
  //////////////////////////////////////////////////

  // Merges dW then db into one output stream
  ntm_gradient_readout u_readout (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .finish        (finish),
    .clear         (clear),
    .accumulate_en (accumulate_en),
    .rd_row        (rd_row),
    .rd_col        (rd_col),
    .w_value       (w_value),
    .b_value       (b_value),
    .grad          (grad),
    .ready         (ready)
  );

endmodule

// ==== tests/ntm_trainer_asserts.sv ====
// NTM trainer output checks
`timescale 1ns/10ps

module ntm_trainer_asserts (
  input logic                       CLK,
  input logic                       RST,
  input ntm_trainer_pkg::ntm_grad_t grad,
  input logic                       ready
);

  //////////////////////////////////////////////////
  // Output stream rules
  //////////////////////////////////////////////////

  // dW and db entries never share a cycle
  valid_exclusive_a: assert property (@(posedge CLK) disable iff (RST)
    !(grad.w_valid && grad.b_valid))
    else $error("w_valid and b_valid high in the same cycle");

  // ready comes after the stream, never inside it
  ready_alone_a: assert property (@(posedge CLK) disable iff (RST)
    !(ready && (grad.w_valid || grad.b_valid)))
    else $error("ready high together with a valid");

  // Single-cycle pulse
  ready_single_a: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else $error("ready high for more than one cycle");

  // Quiet outputs under reset
  reset_quiet_a: assert property (@(posedge CLK)
    RST |-> (!grad.w_valid && !grad.b_valid && !ready))
    else $error("valid or ready high while RST is asserted");

endmodule

bind ntm_trainer ntm_trainer_asserts u_asserts (
  .CLK   (CLK),
  .RST   (RST),
  .grad  (grad),
  .ready (ready)
);

// ==== tests/ntm_trainer_tb.sv ====
// NTM trainer testbench
`timescale 1ns/10ps
`include "ntm_trainer_cfg.svh"

module ntm_trainer_tb;

  import ntm_trainer_pkg::*;

  localparam int L = `NTM_L;
  localparam int X = `NTM_X;
  // dW entries then db entries
  localparam int N_OUT = L * X + L;
  // Longest test runs about 8*(X+L) + L*X + L + 20 cycles
  // Five tests stay far below this limit
  localparam int TIMEOUT_CYCLES = 3000;

  logic        CLK;
  logic        RST;
  logic        start;
  logic        finish;
  ntm_sample_t sample;
  ntm_grad_t   grad;
  logic        ready;

  // Reference model of 32-bit wrapping sums
  int ref_w [L][X];
  int ref_b [L];
  int ref_x [X];
  int x_ptr;
  int d_ptr;

  // Captured output stream
  ntm_grad_t grad_q [$];
  int        grad_cyc [$];
  int        ready_q [$];
  int        neg_cnt = 0;
  int        finish_neg = -1;

  // Bookkeeping
  string cur_test;
  int    error_cnt = 0;
  int    test_err_start = 0;
  int    test_cnt = 0;
  int    failed_tests = 0;
  int    cycle_cnt = 0;

  ntm_trainer dut0 (
    .CLK    (CLK),
    .RST    (RST),
    .start  (start),
    .finish (finish),
    .sample (sample),
    .grad   (grad),
    .ready  (ready)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Output capture at mid-cycle
  //////////////////////////////////////////////////

  always @(negedge CLK) begin
    neg_cnt = neg_cnt + 1;
    // First finish of the pass marks the timing origin
    if (finish && finish_neg < 0) begin
      finish_neg = neg_cnt;
    end
    if (grad.w_valid || grad.b_valid) begin
      grad_q.push_back(grad);
      grad_cyc.push_back(neg_cnt);
    end
    if (ready) begin
      ready_q.push_back(neg_cnt);
    end
  end

  task automatic clear_capture();
    grad_q.delete();
    grad_cyc.delete();
    ready_q.delete();
    finish_neg = -1;
  endtask

  task automatic model_clear();
    for (int l = 0; l < L; l++) begin
      ref_b[l] = 0;
      for (int c = 0; c < X; c++) begin
        ref_w[l][c] = 0;
      end
    end
    x_ptr = 0;
    d_ptr = 0;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic drive_raw(input logic xv, input logic dv, input logic signed [15:0] v);
    @(posedge CLK);
    sample <= '{x_valid: xv, d_valid: dv, data: v};
  endtask

  // One x element into the next slot
  task automatic send_x(input logic signed [15:0] v);
    drive_raw(1'b1, 1'b0, v);
    ref_x[x_ptr] = int'(v);
    x_ptr = (x_ptr + 1) % X;
  endtask

  // One d element adds a dW row and a db entry
  task automatic send_d(input logic signed [15:0] v);
    drive_raw(1'b0, 1'b1, v);
    ref_b[d_ptr] = ref_b[d_ptr] + int'(v);
    for (int c = 0; c < X; c++) begin
      ref_w[d_ptr][c] = ref_w[d_ptr][c] + int'(v) * ref_x[c];
    end
    d_ptr = (d_ptr + 1) % L;
  endtask

  // X x strobes then L d strobes back to back
  task automatic send_step(input bit full_scale);
    logic [31:0] r;
    for (int i = 0; i < X + L; i++) begin
      r = $urandom;
      if (full_scale) begin
        r[15:0] = 16'h8000;
      end
      if (i < X) begin
        send_x(r[15:0]);
      end else begin
        send_d(r[15:0]);
      end
    end
  endtask

  task automatic start_pass();
    clear_capture();
    model_clear();
    @(posedge CLK);
    start <= 1'b1;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  task automatic end_pass();
    @(posedge CLK);
    sample <= '0;
    finish <= 1'b1;
    @(posedge CLK);
    finish <= 1'b0;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready_q.size() == 0 && n < N_OUT + 10) begin
      @(posedge CLK);
      n++;
    end
    if (ready_q.size() == 0) begin
      $display("%s: ready pulse never arrived", cur_test);
      error_cnt++;
    end
    // Room for a stray second pulse to show up
    repeat (2) @(posedge CLK);
  endtask

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("Error %s: %s expected %0d, got %0d", cur_test, what, expected, actual);
      error_cnt++;
    end
  endtask

  // Whole readout against the model
  task automatic check_readout();
    ntm_grad_t g;
    int first;
    int r;
    int c;
    check_value("result count", N_OUT, grad_q.size());
    check_value("ready count", 1, ready_q.size());
    if (grad_q.size() != N_OUT) begin
      return;
    end
    first = grad_cyc[0];
    check_value("cycles from finish to first w_valid", 2, first - finish_neg);
    for (int i = 0; i < N_OUT; i++) begin
      g = grad_q[i];
      check_value($sformatf("cycle of result %0d", i), first + i, grad_cyc[i]);
      if (i < L * X) begin
        // Row-major dW
        r = i / X;
        c = i % X;
        check_value($sformatf("kind of dW(%0d;%0d)", r, c), 2, {g.w_valid, g.b_valid});
        check_value($sformatf("row of dW(%0d;%0d)", r, c), r, g.row);
        check_value($sformatf("col of dW(%0d;%0d)", r, c), c, g.col);
        check_value($sformatf("dW(%0d;%0d)", r, c), ref_w[r][c], $signed(g.value));
      end else begin
        r = i - L * X;
        check_value($sformatf("kind of db(%0d)", r), 1, {g.w_valid, g.b_valid});
        check_value($sformatf("row of db(%0d)", r), r, g.row);
        check_value($sformatf("col of db(%0d)", r), 0, g.col);
        check_value($sformatf("db(%0d)", r), ref_b[r], $signed(g.value));
      end
    end
    if (ready_q.size() == 1) begin
      check_value("ready cycle", first + N_OUT, ready_q[0]);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err_start = error_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (error_cnt == test_err_start) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d errors", cur_test, error_cnt - test_err_start);
      failed_tests++;
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  // Nothing on the outputs through reset or a lone finish
  task automatic reset_idle();
    begin_test("reset_idle");
    repeat (2) @(posedge CLK);
    check_value("results during reset", 0, grad_q.size());
    check_value("ready pulses during reset", 0, ready_q.size());
    @(posedge CLK);
    finish <= 1'b1;
    @(posedge CLK);
    finish <= 1'b0;
    repeat (N_OUT + 8) @(posedge CLK);
    check_value("results after lone finish", 0, grad_q.size());
    check_value("ready pulses after lone finish", 0, ready_q.size());
    end_test();
  endtask

  // Fixed values with negatives and full-scale samples
  task automatic single_step();
    begin_test("single_step");
    start_pass();
    send_x(16'sd3);
    send_x(-16'sd2);
    send_x(16'sd7);
    send_x(16'sh8000);
    send_d(16'sd5);
    send_d(-16'sd4);
    send_d(16'sd32767);
    send_d(-16'sd1);
    end_pass();
    wait_ready();
    check_readout();
    end_test();
  endtask

  // First two steps at -32768 push dW past 2^31
  task automatic multi_step_accumulation();
    begin_test("multi_step_accumulation");
    start_pass();
    for (int s = 0; s < 8; s++) begin
      send_step(s < 2);
    end
    end_pass();
    wait_ready();
    check_readout();
    end_test();
  endtask

  // Strobes, start and finish during readout are dropped
  task automatic readout_order();
    begin_test("readout_order");
    start_pass();
    send_step(1'b0);
    end_pass();
    drive_raw(1'b1, 1'b0, 16'sd1234);
    drive_raw(1'b0, 1'b1, -16'sd999);
    @(posedge CLK);
    sample <= '0;
    start  <= 1'b1;
    @(posedge CLK);
    start  <= 1'b0;
    finish <= 1'b1;
    @(posedge CLK);
    finish <= 1'b0;
    wait_ready();
    check_readout();
    end_test();
  endtask

  // Second pass reports its own sums only
  task automatic clear_between_passes();
    begin_test("clear_between_passes");
    start_pass();
    send_step(1'b0);
    send_step(1'b0);
    end_pass();
    wait_ready();
    check_readout();
    start_pass();
    for (int s = 0; s < 3; s++) begin
      send_step(1'b0);
    end
    end_pass();
    wait_ready();
    check_readout();
    end_test();
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    RST    = 1'b0;
    start  = 1'b0;
    finish = 1'b0;
    sample = '0;
    void'($urandom(32'h405e5df0));
    model_clear();
    // Async reset well ahead of the first clock edge
    #10 RST = 1'b1;
    repeat (4) @(posedge CLK);
    RST <= 1'b0;
    reset_idle();
    single_step();
    multi_step_accumulation();
    readout_order();
    clear_between_passes();
    $display("Tests: %0d run, %0d failed, %0d errors", test_cnt, failed_tests, error_cnt);
    if (error_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+logic
logic/ntm_trainer_pkg.sv
logic/ntm_weight_gradient.sv
logic/ntm_bias_gradient.sv
logic/ntm_gradient_readout.sv
logic/ntm_trainer.sv
tests/ntm_trainer_asserts.sv
tests/ntm_trainer_tb.sv
